/* feedback_delay.sv */
module feedback_delay (
  input  logic                                  clk,
  input  logic                                  reset,
  input  logic                                  i_wr,
  input  logic [2*iir_dsp_pkg::FEEDBACK_W-1:0]  i_wr_data,
  input  logic                                  i_rd,
  input  logic [iir_ctrl_pkg::LEN_W-1:0]        i_len,
  output logic [2*iir_dsp_pkg::FEEDBACK_W-1:0]  o_rd_data
);
  import iir_dsp_pkg::*;
  import iir_ctrl_pkg::*;

  // Store is a power of two deep, so pointers are one bit narrower than lengths
  logic [2*FEEDBACK_W-1:0] mem [MAX_VECTOR_LEN];
  logic [LEN_W-2:0]        wr_ptr;
  logic [LEN_W-2:0]        rd_ptr;
  logic [LEN_W-2:0]        rd_addr;
  logic [LEN_W-1:0]        rd_count;
  logic                    primed;

  // Reads and writes follow the same sample order, so the slot of sample
  // n-len sits len places behind the read pointer
  assign rd_addr = rd_ptr - i_len[LEN_W-2:0];
  // Zero until len samples have gone through, also zero for an unset length
  assign primed  = (rd_count >= i_len) && (i_len != '0);

  // Pointers and fill count
  always_ff @(posedge clk) begin
    if (reset) begin
      wr_ptr   <= '0;
      rd_ptr   <= '0;
      rd_count <= '0;
    end else begin
      if (i_wr) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (i_rd) begin
        rd_ptr <= rd_ptr + 1'b1;
        // Saturates once the whole store has been cycled
        if (rd_count < LEN_W'(MAX_VECTOR_LEN)) begin
          rd_count <= rd_count + 1'b1;
        end
      end
    end
  end

  // Storage and registered read port
  always_ff @(posedge clk) begin
    if (i_wr) begin
      mem[wr_ptr] <= i_wr_data;
    end
    if (i_rd) begin
      o_rd_data <= primed ? mem[rd_addr] : '0;
    end
  end

endmodule

/* filelist.f */
iir_dsp_pkg.sv
iir_ctrl_pkg.sv
lane_bus_if.sv
lane_dispatch.sv
feedback_delay.sv
vector_iir.sv
lane_merge.sv
multi_vector_iir.sv
tb_multi_vector_iir.sv

/* iir_ctrl_pkg.sv */
package iir_ctrl_pkg;

  // ----------------------------------------------------------------------
  // Lane layout
  // ----------------------------------------------------------------------
  localparam int NUM_LANES = 4;
  localparam int LANE_W    = $clog2(NUM_LANES);

  // ----------------------------------------------------------------------
  // Vector length limits
  // ----------------------------------------------------------------------
  // Depth of each feedback store
  localparam int MAX_VECTOR_LEN = 64;
  // Wide enough to hold MAX_VECTOR_LEN itself
  localparam int LEN_W          = $clog2(MAX_VECTOR_LEN) + 1;
  // Lane pipeline needs this many samples between read and write
  localparam int MIN_VECTOR_LEN = 4;

  // Register write opcodes
  typedef enum logic [1:0] {
    CFG_ALPHA = 2'd0,
    CFG_BETA  = 2'd1,
    CFG_LEN   = 2'd2
  } cfg_op_t;

endpackage

/* iir_dsp_pkg.sv */
package iir_dsp_pkg;

  // ----------------------------------------------------------------------
  // Sample and coefficient widths
  // ----------------------------------------------------------------------
  // Complex components, each signed
  localparam int IN_W    = 16;
  localparam int OUT_W   = 16;
  // Q15 coefficients
  localparam int ALPHA_W = 16;
  localparam int BETA_W  = 16;

  // ----------------------------------------------------------------------
  // Internal datapath widths
  // ----------------------------------------------------------------------
  // Stored feedback per component
  localparam int FEEDBACK_W     = 25;
  // Guard bits above the rounding window
  localparam int ACCUM_HEADROOM = 4;
  localparam int FF_PROD_W      = IN_W + BETA_W - 1;
  localparam int FB_PROD_W      = FEEDBACK_W + ALPHA_W - 2;

  // Align feedforward product with scaled feedback
  localparam int FF_SHIFT = FB_PROD_W - FF_PROD_W - ACCUM_HEADROOM;
  // Sum back down to stored feedback width
  localparam int FB_SHIFT = FB_PROD_W - FEEDBACK_W;

  // Rounding window is the sum without its headroom
  localparam int RND_IN_W  = FB_PROD_W - ACCUM_HEADROOM;
  // One extra bit so the half-LSB add cannot wrap
  localparam int RND_W     = RND_IN_W + 1;
  localparam int RND_SHIFT = RND_IN_W - OUT_W;
  localparam int RND_HALF  = 1 << (RND_SHIFT - 1);

  // Register stages from lane input to lane output
  localparam int LANE_LATENCY = 4;

endpackage

/* lane_bus_if.sv */
interface lane_bus_if #(
  parameter int DATA_W = iir_dsp_pkg::IN_W
);

  // One-cycle strobe per sample
  logic                     valid;
  // End of vector, only meaningful with valid
  logic                     last;
  // Complex sample
  logic signed [DATA_W-1:0] data_i;
  logic signed [DATA_W-1:0] data_q;

  // Driver side, every signal registered by the owner
  modport source (
    output valid,
    output last,
    output data_i,
    output data_q
  );

  // Receiver side
  modport sink (
    input valid,
    input last,
    input data_i,
    input data_q
  );

endinterface

/* lane_dispatch.sv */
module lane_dispatch (
  input  logic                                   clk,
  input  logic                                   reset,
  input  logic                                   i_valid,
  input  logic                                   i_last,
  input  logic [iir_ctrl_pkg::LANE_W-1:0]        i_lane,
  input  logic signed [iir_dsp_pkg::IN_W-1:0]    i_data_i,
  input  logic signed [iir_dsp_pkg::IN_W-1:0]    i_data_q,
  input  logic                                   i_cfg_wr,
  input  logic [iir_ctrl_pkg::LANE_W-1:0]        i_cfg_lane,
  input  iir_ctrl_pkg::cfg_op_t                  i_cfg_op,
  input  logic [iir_dsp_pkg::ALPHA_W-1:0]        i_cfg_data,
  output logic signed [iir_dsp_pkg::ALPHA_W-1:0] o_alpha [iir_ctrl_pkg::NUM_LANES],
  output logic signed [iir_dsp_pkg::BETA_W-1:0]  o_beta [iir_ctrl_pkg::NUM_LANES],
  output logic [iir_ctrl_pkg::LEN_W-1:0]         o_len [iir_ctrl_pkg::NUM_LANES],
  lane_bus_if.source                             lanes [iir_ctrl_pkg::NUM_LANES]
);
  import iir_ctrl_pkg::*;

  logic [LEN_W-1:0] len_clamped;

  // Keep lengths inside what the lane pipeline and store support
  always_comb begin
    if (i_cfg_data < MIN_VECTOR_LEN) begin
      len_clamped = LEN_W'(MIN_VECTOR_LEN);
    end else if (i_cfg_data > MAX_VECTOR_LEN) begin
      len_clamped = LEN_W'(MAX_VECTOR_LEN);
    end else begin
      len_clamped = i_cfg_data[LEN_W-1:0];
    end
  end

  // ----------------------------------------------------------------------
  // Per-lane setting registers
  // ----------------------------------------------------------------------
  always_ff @(posedge clk) begin
    for (int l = 0; l < NUM_LANES; l++) begin
      if (reset) begin
        o_alpha[l] <= '0;
        o_beta[l]  <= '0;
        o_len[l]   <= '0;
      end else if (i_cfg_wr && (i_cfg_lane == LANE_W'(l))) begin
        case (i_cfg_op)
          CFG_ALPHA: o_alpha[l] <= i_cfg_data;
          CFG_BETA:  o_beta[l]  <= i_cfg_data;
          CFG_LEN:   o_len[l]   <= len_clamped;
          default:   ;
        endcase
      end
    end
  end

  // ----------------------------------------------------------------------
  // Sample routing, one registered bus per lane
  // ----------------------------------------------------------------------
  for (genvar g = 0; g < NUM_LANES; g++) begin : g_bus
    logic sel;

    // This lane is the target of the incoming sample
    assign sel = i_valid && (i_lane == LANE_W'(g));

    always_ff @(posedge clk) begin
      if (reset) begin
        lanes[g].valid <= 1'b0;
        lanes[g].last  <= 1'b0;
      end else begin
        lanes[g].valid <= sel;
        lanes[g].last  <= sel && i_last;
      end
    end

    // Payload only moves for the addressed lane
    always_ff @(posedge clk) begin
      if (sel) begin
        lanes[g].data_i <= i_data_i;
        lanes[g].data_q <= i_data_q;
      end
    end
  end

endmodule

/* lane_merge.sv */
module lane_merge (
  input  logic                                  clk,
  input  logic                                  reset,
  lane_bus_if.sink                              lanes [iir_ctrl_pkg::NUM_LANES],
  output logic                                  o_valid,
  output logic                                  o_last,
  output logic [iir_ctrl_pkg::LANE_W-1:0]       o_lane,
  output logic signed [iir_dsp_pkg::OUT_W-1:0]  o_data_i,
  output logic signed [iir_dsp_pkg::OUT_W-1:0]  o_data_q
);
  import iir_dsp_pkg::*;
  import iir_ctrl_pkg::*;

  logic [NUM_LANES-1:0]    lane_vld;
  logic [NUM_LANES-1:0]    lane_last;
  logic signed [OUT_W-1:0] lane_i [NUM_LANES];
  logic signed [OUT_W-1:0] lane_q [NUM_LANES];
  logic [LANE_W-1:0]       sel_lane;
  logic                    any_vld;

  // Flatten the bus array so it can be indexed by a variable
  for (genvar g = 0; g < NUM_LANES; g++) begin : g_flat
    assign lane_vld[g]  = lanes[g].valid;
    assign lane_last[g] = lanes[g].last;
    assign lane_i[g]    = lanes[g].data_i;
    assign lane_q[g]    = lanes[g].data_q;
  end

  // Equal lane latency means at most one valid per cycle
  always_comb begin
    sel_lane = '0;
    for (int l = 0; l < NUM_LANES; l++) begin
      if (lane_vld[l]) begin
        sel_lane = LANE_W'(l);
      end
    end
  end

  assign any_vld = |lane_vld;

  always_ff @(posedge clk) begin
    if (reset) begin
      o_valid <= 1'b0;
      o_last  <= 1'b0;
    end else begin
      o_valid <= any_vld;
      o_last  <= any_vld && lane_last[sel_lane];
    end
  end

  // Tag and data held between outputs
  always_ff @(posedge clk) begin
    if (any_vld) begin
      o_lane   <= sel_lane;
      o_data_i <= lane_i[sel_lane];
      o_data_q <= lane_q[sel_lane];
    end
  end

endmodule

/* multi_vector_iir.sv */
module multi_vector_iir (
  input  logic                                  clk,
  input  logic                                  reset,
  input  logic                                  i_valid,
  input  logic                                  i_last,
  input  logic [iir_ctrl_pkg::LANE_W-1:0]       i_lane,
  input  logic signed [iir_dsp_pkg::IN_W-1:0]   i_data_i,
  input  logic signed [iir_dsp_pkg::IN_W-1:0]   i_data_q,
  input  logic                                  i_cfg_wr,
  input  logic [iir_ctrl_pkg::LANE_W-1:0]       i_cfg_lane,
  input  iir_ctrl_pkg::cfg_op_t                 i_cfg_op,
  input  logic [iir_dsp_pkg::ALPHA_W-1:0]       i_cfg_data,
  output logic                                  o_valid,
  output logic                                  o_last,
  output logic [iir_ctrl_pkg::LANE_W-1:0]       o_lane,
  output logic signed [iir_dsp_pkg::OUT_W-1:0]  o_data_i,
  output logic signed [iir_dsp_pkg::OUT_W-1:0]  o_data_q
);
  import iir_dsp_pkg::*;
  import iir_ctrl_pkg::*;

  // Per-lane settings from the dispatcher
  logic signed [ALPHA_W-1:0] lane_alpha [NUM_LANES];
  logic signed [BETA_W-1:0]  lane_beta [NUM_LANES];
  logic [LEN_W-1:0]          lane_len [NUM_LANES];

  // Sample buses into and out of the lanes
  lane_bus_if #(.DATA_W(IN_W))  in_bus  [NUM_LANES] ();
  lane_bus_if #(.DATA_W(OUT_W)) out_bus [NUM_LANES] ();

  lane_dispatch dispatch0 (
    .clk        (clk),
    .reset      (reset),
    .i_valid    (i_valid),
    .i_last     (i_last),
    .i_lane     (i_lane),
    .i_data_i   (i_data_i),
    .i_data_q   (i_data_q),
    .i_cfg_wr   (i_cfg_wr),
    .i_cfg_lane (i_cfg_lane),
    .i_cfg_op   (i_cfg_op),
    .i_cfg_data (i_cfg_data),
    .o_alpha    (lane_alpha),
    .o_beta     (lane_beta),
    .o_len      (lane_len),
    .lanes      (in_bus)
  );

  // Identical filter lanes
  for (genvar g = 0; g < NUM_LANES; g++) begin : g_lane
    vector_iir iir0 (
      .clk     (clk),
      .reset   (reset),
      .i_alpha (lane_alpha[g]),
      .i_beta  (lane_beta[g]),
      .i_len   (lane_len[g]),
      .s_in    (in_bus[g]),
      .m_out   (out_bus[g])
    );
  end

  lane_merge merge0 (
    .clk      (clk),
    .reset    (reset),
    .lanes    (out_bus),
    .o_valid  (o_valid),
    .o_last   (o_last),
    .o_lane   (o_lane),
    .o_data_i (o_data_i),
    .o_data_q (o_data_q)
  );

endmodule

/* run_sim.sh */
#!/bin/sh
# Build with Verilator, run, and pass only when the pass line is printed
cd "$(dirname "$0")" &&
verilator --binary --timing -f filelist.f --top-module tb_multi_vector_iir -o tb_sim &&
./obj_dir/tb_sim 2>&1 | tee /dev/stderr | grep -q "^Simulation passed$" &&
echo "run_sim: PASS" ||
{ echo "run_sim: FAIL"; exit 1; }

/* tb_multi_vector_iir.sv */
module tb_multi_vector_iir;
  timeunit 1ns;
  timeprecision 1ps;
  import iir_dsp_pkg::*;
  import iir_ctrl_pkg::*;

  localparam int CLK_PERIOD  = 8;
  localparam int TOP_LATENCY = 6;
  // Window of the sum that feeds the output rounding
  localparam int RND_WIN     = 35;
  // Samples driven over all tests
  localparam int TOTAL_SAMPLES = 550;
  // Gaps, config writes and drains stay under three idle cycles per sample
  localparam int WATCHDOG_CYCLES = TOTAL_SAMPLES * 4 + 50;

  logic clk;
  logic reset;
  logic i_valid;
  logic i_last;
  logic [LANE_W-1:0] i_lane;
  logic signed [IN_W-1:0] i_data_i;
  logic signed [IN_W-1:0] i_data_q;
  logic i_cfg_wr;
  logic [LANE_W-1:0] i_cfg_lane;
  cfg_op_t i_cfg_op;
  logic [ALPHA_W-1:0] i_cfg_data;
  logic o_valid;
  logic o_last;
  logic [LANE_W-1:0] o_lane;
  logic signed [OUT_W-1:0] o_data_i;
  logic signed [OUT_W-1:0] o_data_q;

  // Expected outputs, pushed at drive time
  logic [LANE_W-1:0] exp_lane [$];
  logic exp_last [$];
  logic [15:0] exp_i [$];
  logic [15:0] exp_q [$];
  int exp_cyc [$];

  // Model of the applied settings and stored feedback per lane
  longint m_alpha [NUM_LANES];
  longint m_beta [NUM_LANES];
  int m_len [NUM_LANES];
  int hist_n [NUM_LANES];
  longint hist_i [NUM_LANES][MAX_VECTOR_LEN];
  longint hist_q [NUM_LANES][MAX_VECTOR_LEN];

  int cyc = 0;
  int errors;
  int checks;
  int last_seen;
  logic ignore_out;
  logic [31:0] rand_state;

  multi_vector_iir dut0 (.*);

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  always @(posedge clk) cyc <= cyc + 1;

  // ----------------------------------------------------------------------
  // Reference model
  // ----------------------------------------------------------------------
  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    s = s ^ (s << 13);
    s = s ^ (s >> 17);
    s = s ^ (s << 5);
    return s;
  endfunction

  // Sign-extended low w bits
  function automatic longint wrap(input longint v, input int w);
    longint m;
    m = v & ((64'sd1 <<< w) - 64'sd1);
    if (m >= (64'sd1 <<< (w - 1))) m = m - (64'sd1 <<< w);
    return m;
  endfunction

  function automatic logic [15:0] ref_output(input longint x, input longint alpha,
                                             input longint beta, input longint fb,
                                             output longint stored);
    longint ff;
    longint fbs;
    longint sum;
    longint shf;
    ff  = wrap(x * beta, FF_PROD_W);
    fbs = wrap(fb * alpha, FB_PROD_W);
    sum = wrap(fbs + ff * (64'sd1 <<< FF_SHIFT), FB_PROD_W);
    stored = wrap(sum >>> FB_SHIFT, FEEDBACK_W);
    // Round half up, then clip to 16 bits signed
    shf = (wrap(sum, RND_WIN) + (64'sd1 <<< 18)) >>> 19;
    if (shf > 32767) shf = 32767;
    if (shf < -32768) shf = -32768;
    return 16'(shf);
  endfunction

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("** Error: %s got 0x%0h expected 0x%0h at %0t", name, got, exp, $time);
    end
  endtask

  // ----------------------------------------------------------------------
  // Stimulus helpers
  // ----------------------------------------------------------------------
  task automatic idle(input int n);
    repeat (n) begin
      @(posedge clk);
      i_valid  <= 1'b0;
      i_last   <= 1'b0;
      i_cfg_wr <= 1'b0;
    end
  endtask

  task automatic cfg_write(input int lane, input cfg_op_t op, input logic [15:0] data);
    @(posedge clk);
    i_valid    <= 1'b0;
    i_cfg_wr   <= 1'b1;
    i_cfg_lane <= LANE_W'(lane);
    i_cfg_op   <= op;
    i_cfg_data <= data;
    case (op)
      CFG_ALPHA: m_alpha[lane] = longint'(signed'(data));
      CFG_BETA:  m_beta[lane]  = longint'(signed'(data));
      default:   m_len[lane]   = int'(data);
    endcase
  endtask

  task automatic setup_lane(input int lane, input logic [15:0] a, input logic [15:0] b,
                            input logic [15:0] len);
    cfg_write(lane, CFG_ALPHA, a);
    cfg_write(lane, CFG_BETA, b);
    cfg_write(lane, CFG_LEN, len);
    idle(3);
  endtask

  task automatic drive_sample(input int lane, input logic [15:0] di, input logic [15:0] dq,
                              input logic last);
    longint fb_i;
    longint fb_q;
    longint st_i;
    longint st_q;
    int n;
    n = hist_n[lane];
    fb_i = 0;
    fb_q = 0;
    if (m_len[lane] != 0 && n >= m_len[lane]) begin
      fb_i = hist_i[lane][(n - m_len[lane]) % MAX_VECTOR_LEN];
      fb_q = hist_q[lane][(n - m_len[lane]) % MAX_VECTOR_LEN];
    end
    exp_i.push_back(ref_output(longint'(signed'(di)), m_alpha[lane], m_beta[lane], fb_i,
                               st_i));
    exp_q.push_back(ref_output(longint'(signed'(dq)), m_alpha[lane], m_beta[lane], fb_q,
                               st_q));
    exp_lane.push_back(LANE_W'(lane));
    exp_last.push_back(last);
    hist_i[lane][n % MAX_VECTOR_LEN] = st_i;
    hist_q[lane][n % MAX_VECTOR_LEN] = st_q;
    hist_n[lane] = n + 1;
    @(posedge clk);
    i_valid  <= 1'b1;
    i_last   <= last;
    i_lane   <= LANE_W'(lane);
    i_data_i <= di;
    i_data_q <= dq;
    i_cfg_wr <= 1'b0;
    exp_cyc.push_back(cyc + 1 + TOP_LATENCY);
  endtask

  task automatic drive_random(input int lane, input int idx);
    logic [31:0] r;
    rand_state = xorshift32(rand_state);
    r = rand_state;
    drive_sample(lane, r[15:0], r[31:16], (idx % m_len[lane]) == m_len[lane] - 1);
  endtask

  task automatic clear_expected();
    exp_lane.delete();
    exp_last.delete();
    exp_i.delete();
    exp_q.delete();
    exp_cyc.delete();
  endtask

  // Waits for all pending outputs, then reports the test
  task automatic finish_test(input int num, input string name, input int err_before);
    int t;
    idle(1);
    t = 0;
    while (exp_i.size() != 0 && t < 20) begin
      @(posedge clk);
      t++;
    end
    if (exp_i.size() != 0) begin
      errors++;
      $display("%0d expected outputs never arrived", exp_i.size());
      clear_expected();
    end
    $display("test %0d %s: %s", num, name, (errors == err_before) ? "ok" : "FAILED");
  endtask

  // ----------------------------------------------------------------------
  // Compare process, samples outputs away from the rising edge
  // ----------------------------------------------------------------------
  always @(negedge clk) begin
    if (!reset && !ignore_out && o_valid) begin
      if (exp_i.size() == 0) begin
        errors++;
        $display("Output on lane %0d arrived with no sample pending", o_lane);
      end else begin
        check_value("o_lane", 32'(o_lane), 32'(exp_lane.pop_front()));
        check_value("o_last", 32'(o_last), 32'(exp_last.pop_front()));
        check_value("o_data_i", 32'($unsigned(o_data_i)), 32'(exp_i.pop_front()));
        check_value("o_data_q", 32'($unsigned(o_data_q)), 32'(exp_q.pop_front()));
        check_value("latency", 32'(cyc), 32'(exp_cyc.pop_front()));
        if (o_last) last_seen++;
      end
    end
  end

  initial begin
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    $display("Watchdog expired before the tests finished");
    $display("Simulation failed");
    $finish;
  end

  // ----------------------------------------------------------------------
  // Test sequence
  // ----------------------------------------------------------------------
  initial begin
    int e;
    logic [31:0] r;
    reset <= 1'b1;
    i_valid <= 1'b0;
    i_last <= 1'b0;
    i_lane <= '0;
    i_data_i <= '0;
    i_data_q <= '0;
    i_cfg_wr <= 1'b0;
    i_cfg_lane <= '0;
    i_cfg_op <= CFG_ALPHA;
    i_cfg_data <= '0;
    errors = 0;
    checks = 0;
    last_seen = 0;
    ignore_out = 1'b0;
    rand_state = 32'hbe66;
    for (int l = 0; l < NUM_LANES; l++) begin
      m_alpha[l] = 0;
      m_beta[l] = 0;
      m_len[l] = 0;
      hist_n[l] = 0;
    end
    repeat (4) @(posedge clk);
    reset <= 1'b0;

    // Impulse with alpha 0.5, echoes every 4 samples
    e = errors;
    setup_lane(0, 16'd16384, 16'd32767, 16'd4);
    drive_sample(0, 16'd20000, -16'sd12000, 1'b0);
    for (int k = 1; k < 24; k++) drive_sample(0, 16'd0, 16'd0, (k % 4) == 3);
    finish_test(1, "impulse response", e);

    // Four lanes with their own settings, round robin
    e = errors;
    setup_lane(0, 16'd12000, 16'd20000, 16'd4);
    setup_lane(1, 16'd30000, 16'd8000, 16'd7);
    setup_lane(2, -16'sd9000, 16'd32767, 16'd16);
    setup_lane(3, 16'd24000, -16'sd15000, 16'd64);
    for (int k = 0; k < 80; k++) begin
      for (int l = 0; l < NUM_LANES; l++) drive_random(l, hist_n[l]);
    end
    finish_test(2, "lane independence", e);

    // Random lanes with bursts and gaps
    e = errors;
    for (int k = 0; k < 120; k++) begin
      rand_state = xorshift32(rand_state);
      r = rand_state;
      drive_random(int'(r[1:0]), hist_n[r[1:0]]);
      if (r[4]) idle(int'(r[6:5]) + 1);
    end
    finish_test(3, "gapped input", e);

    // Full-scale input with alpha near one
    e = errors;
    // Alpha 0 first, so only the full-scale vector reaches the store
    setup_lane(1, 16'd0, 16'd32767, 16'd4);
    for (int k = 0; k < 4; k++) drive_sample(1, 16'h7fff, 16'h8000, k == 3);
    // Loop gain just above one pushes the first echo past the positive limit
    cfg_write(1, CFG_ALPHA, 16'd16385);
    for (int k = 4; k < 40; k++) drive_sample(1, 16'h0000, 16'h0000, (k % 4) == 3);
    finish_test(4, "saturation and rounding", e);

    // Three vectors, each end marked
    e = errors;
    last_seen = 0;
    for (int k = 0; k < 12; k++) drive_random(0, k);
    finish_test(5, "last propagation", e);
    if (last_seen != 3) begin
      errors++;
      $display("Saw %0d last flags where 3 vectors ended", last_seen);
    end

    // Reset with samples still in flight
    e = errors;
    for (int k = 0; k < 10; k++) drive_random(2, hist_n[2]);
    @(posedge clk);
    ignore_out = 1'b1;
    reset <= 1'b1;
    i_valid <= 1'b0;
    repeat (4) @(posedge clk);
    @(negedge clk);
    check_value("o_valid", 32'(o_valid), 32'd0);
    @(posedge clk);
    reset <= 1'b0;
    clear_expected();
    for (int l = 0; l < NUM_LANES; l++) begin
      m_alpha[l] = 0;
      m_beta[l] = 0;
      m_len[l] = 0;
      hist_n[l] = 0;
    end
    @(negedge clk);
    check_value("o_valid", 32'(o_valid), 32'd0);
    ignore_out = 1'b0;
    setup_lane(2, 16'd20000, 16'd30000, 16'd5);
    for (int k = 0; k < 24; k++) drive_random(2, k);
    finish_test(6, "reset state", e);

    $display("checks %0d, errors %0d", checks, errors);
    if (errors == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

/* vector_iir.sv */
module vector_iir (
  input  logic                                   clk,
  input  logic                                   reset,
  input  logic signed [iir_dsp_pkg::ALPHA_W-1:0] i_alpha,
  input  logic signed [iir_dsp_pkg::BETA_W-1:0]  i_beta,
  input  logic [iir_ctrl_pkg::LEN_W-1:0]         i_len,
  lane_bus_if.sink                               s_in,
  lane_bus_if.source                             m_out
);
  import iir_dsp_pkg::*;
  import iir_ctrl_pkg::*;

  // Settings, registered every cycle
  logic signed [ALPHA_W-1:0]    cfg_alpha;
  logic signed [BETA_W-1:0]     cfg_beta;
  logic [LEN_W-1:0]             cfg_len;
  // Stage valid and last flags, bit k marks stage k
  logic [LANE_LATENCY-1:0]      vld_sr;
  logic [LANE_LATENCY-1:0]      last_sr;
  // Datapath registers
  logic signed [IN_W-1:0]       in_i;
  logic signed [IN_W-1:0]       in_q;
  logic signed [FF_PROD_W-1:0]  ff_prod_i;
  logic signed [FF_PROD_W-1:0]  ff_prod_q;
  logic signed [FB_PROD_W-1:0]  fb_scaled_i;
  logic signed [FB_PROD_W-1:0]  fb_scaled_q;
  logic signed [FB_PROD_W-1:0]  sum_i;
  logic signed [FB_PROD_W-1:0]  sum_q;
  // Feedback store traffic
  logic [2*FEEDBACK_W-1:0]      fb_wr;
  logic [2*FEEDBACK_W-1:0]      fb_rd;
  logic signed [FEEDBACK_W-1:0] fb_del_i;
  logic signed [FEEDBACK_W-1:0] fb_del_q;

  // Round half up on the low RND_IN_W bits, then clip to OUT_W
  function automatic logic signed [OUT_W-1:0] round_sat(
    input logic signed [FB_PROD_W-1:0] sum
  );
    logic signed [RND_W-1:0] rnd;
    logic signed [RND_W-1:0] shf;
    rnd = RND_W'(signed'(sum[RND_IN_W-1:0])) + RND_W'(RND_HALF);
    shf = rnd >>> RND_SHIFT;
    // In range when every bit above the output sign agrees with it
    if ((&shf[RND_W-1:OUT_W-1]) || !(|shf[RND_W-1:OUT_W-1])) begin
      return shf[OUT_W-1:0];
    end else if (shf[RND_W-1]) begin
      return {1'b1, {(OUT_W-1){1'b0}}};
    end else begin
      return {1'b0, {(OUT_W-1){1'b1}}};
    end
  endfunction

  always_ff @(posedge clk) begin
    if (reset) begin
      cfg_alpha <= '0;
      cfg_beta  <= '0;
      cfg_len   <= '0;
      vld_sr    <= '0;
      last_sr   <= '0;
    end else begin
      cfg_alpha <= i_alpha;
      cfg_beta  <= i_beta;
      cfg_len   <= i_len;
      // Runs every cycle, no back-pressure
      vld_sr    <= {vld_sr[LANE_LATENCY-2:0], s_in.valid};
      last_sr   <= {last_sr[LANE_LATENCY-2:0], s_in.valid && s_in.last};
    end
  end

  // ----------------------------------------------------------------------
  // Four-stage datapath, each stage enabled by its valid flag
  // ----------------------------------------------------------------------
  always_ff @(posedge clk) begin
    // Stage 0, input register
    if (s_in.valid) begin
      in_i <= s_in.data_i;
      in_q <= s_in.data_q;
    end
    // Stage 1, x*beta and y[n-len]*alpha
    if (vld_sr[0]) begin
      ff_prod_i   <= FF_PROD_W'(in_i) * FF_PROD_W'(cfg_beta);
      ff_prod_q   <= FF_PROD_W'(in_q) * FF_PROD_W'(cfg_beta);
      fb_scaled_i <= FB_PROD_W'(fb_del_i) * FB_PROD_W'(cfg_alpha);
      fb_scaled_q <= FB_PROD_W'(fb_del_q) * FB_PROD_W'(cfg_alpha);
    end
    // Stage 2, y[n], wraps in FB_PROD_W bits
    if (vld_sr[1]) begin
      sum_i <= fb_scaled_i + (FB_PROD_W'(ff_prod_i) <<< FF_SHIFT);
      sum_q <= fb_scaled_q + (FB_PROD_W'(ff_prod_q) <<< FF_SHIFT);
    end
    // Stage 3, rounded and saturated output
    if (vld_sr[2]) begin
      m_out.data_i <= round_sat(sum_i);
      m_out.data_q <= round_sat(sum_q);
    end
  end

  assign m_out.valid = vld_sr[LANE_LATENCY-1];
  assign m_out.last  = last_sr[LANE_LATENCY-1];

  // Truncated sum goes back into the store
  assign fb_wr    = {FEEDBACK_W'(sum_i >>> FB_SHIFT), FEEDBACK_W'(sum_q >>> FB_SHIFT)};
  assign fb_del_i = fb_rd[2*FEEDBACK_W-1:FEEDBACK_W];
  assign fb_del_q = fb_rd[FEEDBACK_W-1:0];

  // Read issued as a sample enters stage 0, write once its sum is ready
  feedback_delay fb_store (
    .clk       (clk),
    .reset     (reset),
    .i_wr      (vld_sr[2]),
    .i_wr_data (fb_wr),
    .i_rd      (s_in.valid),
    .i_len     (cfg_len),
    .o_rd_data (fb_rd)
  );

endmodule
